// ==== design/pio_pkg.sv ====
/*
 * PIO execution core shared definitions. Word and field types, opcode and
 * operand encodings, and the count helpers used by the shift units.
 */
package pio_pkg;

  localparam int WORD_BITS  = 32;
  localparam int FULL_COUNT = 32; // Shift count meaning full or empty

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [15:0]          instr_t;
  typedef logic [4:0]           pc_t;
  typedef logic [4:0]           pin_idx_t;
  typedef logic [5:0]           bit_cnt_t;

  // Instruction class, instr[15:13]
  typedef enum logic [2:0] {
    OP_JMP       = 3'd0,
    OP_WAIT      = 3'd1,
    OP_IN        = 3'd2,
    OP_OUT       = 3'd3,
    OP_PUSH_PULL = 3'd4,
    OP_MOV       = 3'd5,
    OP_IRQ       = 3'd6,
    OP_SET       = 3'd7
  } opcode_e;

  // IN sources
  localparam logic [2:0] SRC_PINS = 3'd0;
  localparam logic [2:0] SRC_X    = 3'd1;
  localparam logic [2:0] SRC_Y    = 3'd2;
  localparam logic [2:0] SRC_NULL = 3'd3;

  // OUT and SET destinations
  localparam logic [2:0] DST_PINS    = 3'd0;
  localparam logic [2:0] DST_X       = 3'd1;
  localparam logic [2:0] DST_Y       = 3'd2;
  localparam logic [2:0] DST_NULL    = 3'd3;
  localparam logic [2:0] DST_PINDIRS = 3'd4;

  // JMP conditions
  localparam logic [2:0] COND_ALWAYS        = 3'd0;
  localparam logic [2:0] COND_X_ZERO        = 3'd1;
  localparam logic [2:0] COND_X_DEC         = 3'd2;
  localparam logic [2:0] COND_Y_ZERO        = 3'd3;
  localparam logic [2:0] COND_Y_DEC         = 3'd4;
  localparam logic [2:0] COND_X_NE_Y        = 3'd5;
  localparam logic [2:0] COND_PIN           = 3'd6;
  localparam logic [2:0] COND_OSR_NOT_EMPTY = 3'd7;

  // 5-bit count field, 0 encodes 32
  function automatic bit_cnt_t field_count(pin_idx_t f);
    return (f == '0) ? bit_cnt_t'(FULL_COUNT) : {1'b0, f};
  endfunction

  // Ones in the low n bits, all ones from 32 upward
  function automatic word_t low_mask(bit_cnt_t n);
    return (n >= bit_cnt_t'(FULL_COUNT)) ? '1 : (word_t'(1) << n) - word_t'(1);
  endfunction

  function automatic bit_cnt_t sat_add(bit_cnt_t a, bit_cnt_t b);
    logic [6:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return (sum >= 7'(FULL_COUNT)) ? bit_cnt_t'(FULL_COUNT) : sum[5:0];
  endfunction

endpackage

// ==== design/pio_shift_if.sv ====
/*
 * Shift register control bus. The executor drives the strobes, the shift
 * unit returns its contents, shifted-out bits and bit count.
 */
interface pio_shift_if import pio_pkg::*; ();

  logic     load;       // Replace contents
  word_t    load_data;
  logic     shift;      // Shift this cycle
  pin_idx_t shift_bits; // 0 means 32
  word_t    shift_data; // ISR only
  word_t    contents;
  word_t    out_bits;   // OSR only
  bit_cnt_t count;

  modport ctrl (
    output load, load_data, shift, shift_bits, shift_data,
    input  contents, out_bits, count
  );

  modport unit (
    input  load, load_data, shift, shift_bits, shift_data,
    output contents, out_bits, count
  );

endinterface

// ==== design/pio_shift_in.sv ====
/*
 * Input shift register. Shifts n bits in from either end, counts them up to
 * a saturating 32 and clears when loaded on a push.
 */
module pio_shift_in import pio_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       shift_dir, // 1 shifts right
  pio_shift_if.unit bus
);

  word_t    shreg;
  bit_cnt_t cnt;
  bit_cnt_t amount;
  word_t    data_in;
  word_t    base_reg;
  bit_cnt_t base_cnt;

  assign amount  = field_count(bus.shift_bits);
  assign data_in = bus.shift_data & low_mask(amount); // Only n new bits

  // A load in the same cycle is applied before the shift
  assign base_reg = bus.load ? bus.load_data : shreg;
  assign base_cnt = bus.load ? '0 : cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      shreg <= '0;
      cnt   <= '0;
    end else if (bus.shift) begin
      if (shift_dir) begin
        shreg <= (base_reg >> amount) | (data_in << (bit_cnt_t'(WORD_BITS) - amount));
      end else begin
        shreg <= (base_reg << amount) | data_in;
      end
      cnt <= sat_add(base_cnt, amount);
    end else if (bus.load) begin
      shreg <= bus.load_data;
      cnt   <= '0;
    end
  end

  assign bus.contents = shreg;
  assign bus.count    = cnt;
  assign bus.out_bits = '0; // Nothing leaves the ISR

endmodule

// ==== design/pio_shift_out.sv ====
/*
 * Output shift register. Presents the next n bits right-aligned, shifts them
 * out with zero fill and counts up to 32, which means empty.
 */
module pio_shift_out import pio_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       shift_dir, // 1 shifts right
  pio_shift_if.unit bus
);

  word_t    shreg;
  bit_cnt_t cnt;
  bit_cnt_t amount;
  word_t    base_reg;
  bit_cnt_t base_cnt;

  assign amount = field_count(bus.shift_bits);

  // Bits that leave on this shift, zero extended
  always_comb begin
    if (shift_dir) begin
      bus.out_bits = shreg & low_mask(amount);
    end else begin
      bus.out_bits = shreg >> (bit_cnt_t'(WORD_BITS) - amount); // Top n bits
    end
  end

  assign base_reg = bus.load ? bus.load_data : shreg;
  assign base_cnt = bus.load ? '0 : cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      shreg <= '0;
      cnt   <= bit_cnt_t'(FULL_COUNT); // Empty out of reset
    end else if (bus.shift) begin
      if (shift_dir) begin
        shreg <= base_reg >> amount;
      end else begin
        shreg <= base_reg << amount;
      end
      cnt <= sat_add(base_cnt, amount);
    end else if (bus.load) begin
      shreg <= bus.load_data;
      cnt   <= '0;
    end
  end

  assign bus.contents = shreg;
  assign bus.count    = cnt;

endmodule

// ==== design/pio_exec.sv ====
/*
 * PIO instruction decoder and executor. Holds PC, X, Y and the pin
 * registers, and drives the shift units, FIFO strobes and stall.
 */
module pio_exec import pio_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       en,
  input  instr_t     instr,
  input  word_t      input_pins,
  input  pc_t        wrap_target,
  input  pc_t        wrap_top,
  input  pin_idx_t   jmp_pin,
  input  pin_idx_t   pins_in_base,
  input  pin_idx_t   pins_out_base,
  input  pin_idx_t   pins_set_base,
  input  bit_cnt_t   pins_out_count,
  input  logic [2:0] pins_set_count,
  input  logic       auto_push,
  input  logic       auto_pull,
  input  pin_idx_t   isr_threshold,
  input  pin_idx_t   osr_threshold,
  input  word_t      tx_data,
  input  logic       tx_empty,
  input  logic       rx_full,
  pio_shift_if.ctrl  isr,
  pio_shift_if.ctrl  osr,
  output pc_t        pc,
  output word_t      output_pins,
  output word_t      pin_directions,
  output logic       push,
  output logic       pull,
  output logic       stalled
);

  opcode_e    op;
  logic [2:0] op1;
  pin_idx_t   op2;
  bit_cnt_t   isr_thr;
  bit_cnt_t   osr_thr;
  logic [2*WORD_BITS-1:0] in_pins_dbl;
  word_t      in_pins;
  word_t      x;
  word_t      y;
  word_t      x_next;
  word_t      y_next;
  word_t      pins_next;
  word_t      dirs_next;
  word_t      in_data;
  logic       in_valid;
  logic       jump;
  pc_t        seq_pc;

  function automatic word_t rotl(word_t w, pin_idx_t n);
    logic [2*WORD_BITS-1:0] d;
    d = {w, w} << n;
    return d[2*WORD_BITS-1:WORD_BITS];
  endfunction

  // Write count bits of val from pin base upward, wrapping at 32
  function automatic word_t write_pins(word_t cur, word_t val, pin_idx_t base,
                                       bit_cnt_t count);
    word_t mask;
    mask = rotl(low_mask(count), base);
    return (cur & ~mask) | (rotl(val, base) & mask);
  endfunction

  assign op  = opcode_e'(instr[15:13]);
  assign op1 = instr[7:5];
  assign op2 = instr[4:0]; // Bits 12:8 ignored

  assign isr_thr = field_count(isr_threshold);
  assign osr_thr = field_count(osr_threshold);

  // Input pins seen from pins_in_base
  assign in_pins_dbl = {input_pins, input_pins} >> pins_in_base;
  assign in_pins     = in_pins_dbl[WORD_BITS-1:0];

  assign isr.shift_bits = op2;
  assign isr.shift_data = in_data;
  assign isr.load_data  = '0; // ISR loads only to clear
  assign osr.shift_bits = op2;
  assign osr.shift_data = '0;
  assign osr.load_data  = tx_empty ? x : tx_data; // X when PULL noblock finds no data

  always_comb begin
    x_next    = x;
    y_next    = y;
    pins_next = output_pins;
    dirs_next = pin_directions;
    jump      = 1'b0;
    stalled   = 1'b0;
    push      = 1'b0;
    pull      = 1'b0;
    in_data   = '0;
    in_valid  = 1'b0;
    isr.load  = 1'b0;
    isr.shift = 1'b0;
    osr.load  = 1'b0;
    osr.shift = 1'b0;
    if (en) begin
      case (op)
        OP_JMP: begin
          case (op1)
            COND_ALWAYS: jump = 1'b1;
            COND_X_ZERO: jump = (x == '0);
            COND_X_DEC: begin
              jump = (x != '0);
              if (jump) x_next = x - word_t'(1); // Decrement after test
            end
            COND_Y_ZERO: jump = (y == '0);
            COND_Y_DEC: begin
              jump = (y != '0);
              if (jump) y_next = y - word_t'(1);
            end
            COND_X_NE_Y: jump = (x != y);
            COND_PIN: jump = input_pins[jmp_pin];
            COND_OSR_NOT_EMPTY: jump = (osr.count < osr_thr);
            default: jump = 1'b0;
          endcase
        end
        OP_WAIT: begin
          case (op1[1:0])
            2'd0: stalled = (input_pins[op2] != op1[2]);
            2'd1: stalled = (input_pins[pin_idx_t'(pins_in_base + op2)] != op1[2]);
            default: stalled = 1'b0; // IRQ source not supported
          endcase
        end
        OP_IN: begin
          in_valid = 1'b1;
          case (op1)
            SRC_PINS: in_data = in_pins;
            SRC_X:    in_data = x;
            SRC_Y:    in_data = y;
            SRC_NULL: in_data = '0;
            default:  in_valid = 1'b0;
          endcase
          // Full ISR is pushed and cleared before this shift
          if (in_valid && auto_push && isr.count >= isr_thr) begin
            if (rx_full) begin
              stalled = 1'b1;
            end else begin
              push      = 1'b1;
              isr.load  = 1'b1;
              isr.shift = 1'b1;
            end
          end else begin
            isr.shift = in_valid;
          end
        end
        OP_OUT: begin
          if (auto_pull && osr.count >= osr_thr) begin
            stalled  = 1'b1; // Refill now, OUT retries next cycle
            pull     = !tx_empty;
            osr.load = !tx_empty;
          end else begin
            osr.shift = 1'b1;
            case (op1)
              DST_PINS: pins_next = write_pins(output_pins, osr.out_bits, pins_out_base,
                                               pins_out_count);
              DST_X:    x_next = osr.out_bits;
              DST_Y:    y_next = osr.out_bits;
              DST_NULL: ; // Bits discarded
              DST_PINDIRS: dirs_next = write_pins(pin_directions, osr.out_bits,
                                                  pins_out_base, pins_out_count);
              default:  osr.shift = 1'b0;
            endcase
          end
        end
        OP_PUSH_PULL: begin
          if (!op1[2]) begin
            if (op1[0] && rx_full) begin
              stalled = 1'b1; // Blocking PUSH
            end else begin
              push     = 1'b1;
              isr.load = 1'b1;
            end
          end else if (!tx_empty) begin
            pull     = 1'b1;
            osr.load = 1'b1;
          end else if (op1[0]) begin
            stalled = 1'b1; // Blocking PULL
          end else begin
            osr.load = 1'b1;
          end
        end
        OP_MOV, OP_IRQ: ; // No-ops, PC advances
        OP_SET: begin
          case (op1)
            DST_PINS: pins_next = write_pins(output_pins, word_t'(op2), pins_set_base,
                                             bit_cnt_t'(pins_set_count));
            DST_X:    x_next = word_t'(op2);
            DST_Y:    y_next = word_t'(op2);
            DST_PINDIRS: dirs_next = write_pins(pin_directions, word_t'(op2), pins_set_base,
                                                bit_cnt_t'(pins_set_count));
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  assign seq_pc = (pc == wrap_top) ? wrap_target : pc + pc_t'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc             <= '0;
      x              <= '0;
      y              <= '0;
      output_pins    <= '0;
      pin_directions <= '0;
    end else if (en) begin
      if (!stalled) pc <= jump ? op2 : seq_pc;
      x              <= x_next;
      y              <= y_next;
      output_pins    <= pins_next;
      pin_directions <= dirs_next;
    end
  end

endmodule

// ==== design/pio_machine.sv ====
/*
 * PIO state machine core. Executor plus input and output shift registers,
 * with program memory and FIFOs outside.
 */
module pio_machine import pio_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       en,
  input  instr_t     instr,
  input  word_t      input_pins,
  input  pc_t        wrap_target,
  input  pc_t        wrap_top,
  input  pin_idx_t   jmp_pin,
  input  pin_idx_t   pins_in_base,
  input  pin_idx_t   pins_out_base,
  input  pin_idx_t   pins_set_base,
  input  bit_cnt_t   pins_out_count,
  input  logic [2:0] pins_set_count,
  input  logic       auto_push,
  input  logic       auto_pull,
  input  pin_idx_t   isr_threshold,
  input  pin_idx_t   osr_threshold,
  input  logic       in_shift_dir,
  input  logic       out_shift_dir,
  input  word_t      tx_data,
  input  logic       tx_empty,
  input  logic       rx_full,
  output pc_t        pc,
  output word_t      output_pins,
  output word_t      pin_directions,
  output logic       push,
  output logic       pull,
  output logic       stalled,
  output word_t      rx_data
);

  pio_shift_if isr_bus ();
  pio_shift_if osr_bus ();

  assign rx_data = isr_bus.contents; // Pushed word is the ISR before clear

  pio_shift_in i_isr (
    .clk       (clk),
    .reset     (reset),
    .shift_dir (in_shift_dir),
    .bus       (isr_bus.unit)
  );

  pio_shift_out i_osr (
    .clk       (clk),
    .reset     (reset),
    .shift_dir (out_shift_dir),
    .bus       (osr_bus.unit)
  );

  pio_exec i_exec (
    .clk            (clk),
    .reset          (reset),
    .en             (en),
    .instr          (instr),
    .input_pins     (input_pins),
    .wrap_target    (wrap_target),
    .wrap_top       (wrap_top),
    .jmp_pin        (jmp_pin),
    .pins_in_base   (pins_in_base),
    .pins_out_base  (pins_out_base),
    .pins_set_base  (pins_set_base),
    .pins_out_count (pins_out_count),
    .pins_set_count (pins_set_count),
    .auto_push      (auto_push),
    .auto_pull      (auto_pull),
    .isr_threshold  (isr_threshold),
    .osr_threshold  (osr_threshold),
    .tx_data        (tx_data),
    .tx_empty       (tx_empty),
    .rx_full        (rx_full),
    .isr            (isr_bus.ctrl),
    .osr            (osr_bus.ctrl),
    .pc             (pc),
    .output_pins    (output_pins),
    .pin_directions (pin_directions),
    .push           (push),
    .pull           (pull),
    .stalled        (stalled)
  );

endmodule

// ==== testbench/pio_machine_sva.sv ====
/*
 * Bound checks for the PIO core. Covers the TX pull strobe, PC hold on
 * stall and the quiet state right after reset.
 */
module pio_machine_sva import pio_pkg::*; (
  input logic clk,
  input logic reset,
  input logic tx_empty,
  input logic push,
  input logic pull,
  input logic stalled,
  input pc_t  pc
);

  pull_needs_data: assert property (@(posedge clk) disable iff (reset) pull |-> !tx_empty)
    else $error("pull raised while tx_empty is high");

  // Stalled instruction is retried, so the PC must not move
  stall_holds_pc: assert property (@(posedge clk) disable iff (reset) stalled |=> $stable(pc))
    else $error("pc changed after a stalled cycle");

  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> !push && !pull && !stalled && pc == '0)
    else $error("strobes or pc not idle in the cycle after reset");

endmodule

bind pio_machine pio_machine_sva i_sva (
  .clk      (clk),
  .reset    (reset),
  .tx_empty (tx_empty),
  .push     (push),
  .pull     (pull),
  .stalled  (stalled),
  .pc       (pc)
);

// ==== testbench/tb_pio_machine.sv ====
/*
 * Testbench for the PIO core. Program memory and FIFO models around the DUT,
 * expected words and pins from reference functions.
 */
module tb_pio_machine import pio_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int WORD_CYCLES  = 40; // Budget per word with random stalls
  localparam int BYTE_WORDS   = 8;
  localparam int RANDOM_WORDS = 40;
  localparam int LOOP_CYCLES  = 150;
  localparam int WAIT_CYCLES  = 100;
  localparam int PIN_CYCLES   = 50;
  localparam int SETUP_CYCLES = 40;
  localparam int TEST_COUNT   = 8;
  localparam int WATCHDOG_CYCLES = 2 * ((BYTE_WORDS + RANDOM_WORDS) * WORD_CYCLES +
    3 * LOOP_CYCLES + WAIT_CYCLES + 2 * PIN_CYCLES + TEST_COUNT * SETUP_CYCLES);

  logic clk = 1'b0;
  logic reset, en, auto_push, auto_pull, in_shift_dir, out_shift_dir;
  logic tx_empty, rx_full, push, pull, stalled;
  instr_t instr;
  word_t input_pins, tx_data, output_pins, pin_directions, rx_data;
  pc_t wrap_target, wrap_top, pc;
  pin_idx_t jmp_pin, pins_in_base, pins_out_base, pins_set_base;
  pin_idx_t isr_threshold, osr_threshold;
  bit_cnt_t pins_out_count;
  logic [2:0] pins_set_count;

  instr_t prog [32];
  word_t tx_fifo [$];
  word_t rx_fifo [$];
  word_t rx_expected [$];
  word_t rx_word;
  integer seed;
  string test_name;
  logic random_flags, hold_empty, pin_prev;
  int edge_count;
  int value_errors = 0;
  int other_errors = 0;
  int rx_mismatches = 0;
  int fifo_faults = 0;

  pio_machine i_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign instr = prog[pc]; // Program memory read

  function automatic instr_t encode(opcode_e op, logic [2:0] a, logic [4:0] b);
    return {op, 5'b00000, a, b};
  endfunction

  // Byte order after four OUT 8 and IN 8 rounds
  function automatic word_t expected_rx_word(word_t w, logic out_right, logic in_right);
    word_t r;
    logic [7:0] b;
    int i;
    r = '0;
    for (i = 0; i < 4; i++) begin
      b = out_right ? w[8*i +: 8] : w[8*(3-i) +: 8];
      r = in_right ? {b, r[31:8]} : {r[23:0], b};
    end
    return r;
  endfunction

  function automatic word_t rotate_right(word_t w, int n);
    word_t r;
    int i;
    for (i = 0; i < 32; i++) r[i] = w[(i + n) % 32];
    return r;
  endfunction

  function automatic word_t expected_pins(word_t prev, word_t val, int base, int count);
    word_t r;
    int i;
    r = prev;
    for (i = 0; i < count; i++) r[(base + i) % 32] = val[i];
    return r;
  endfunction

  // RX model with comparison and TX pop
  always @(posedge clk) begin
    if (reset) begin
      rx_fifo.delete();
    end else begin
      if (pull) begin
        assert (!tx_empty) else begin
          fifo_faults++;
          $display("%s: pull raised while the TX FIFO was empty", test_name);
        end
        if (tx_fifo.size() > 0) tx_fifo.delete(0);
      end
      if (push && !rx_full) begin
        rx_fifo.push_back(rx_data);
        if (rx_expected.size() == 0) begin
          fifo_faults++;
          $display("%s: unexpected RX word %h", test_name, rx_data);
        end else begin
          rx_word = rx_expected.pop_front();
          assert (rx_data == rx_word) else begin
            rx_mismatches++;
            $display("ERROR %s: expected %h, actual %h", test_name, rx_word, rx_data);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      edge_count = 0;
      pin_prev   = 1'b0;
    end else begin
      if (output_pins[pins_set_base] && !pin_prev) edge_count++;
      pin_prev = output_pins[pins_set_base];
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // FIFO flags follow the queues from the falling edge
  task automatic next_cycle();
    logic [31:0] rnd;
    logic stall_empty;
    @(negedge clk);
    if (random_flags) begin
      rnd = $random(seed);
      stall_empty = rnd[0];
      rx_full     = rnd[1];
    end else begin
      stall_empty = hold_empty;
      rx_full     = 1'b0;
    end
    tx_empty = (tx_fifo.size() == 0) || stall_empty;
    tx_data  = (tx_fifo.size() > 0) ? tx_fifo[0] : '0;
  endtask

  task automatic load_defaults();
    int i;
    random_flags = 1'b0;
    hold_empty   = 1'b0;
    {input_pins, tx_data} = '0;
    {tx_empty, rx_full} = 2'b10;
    wrap_target = '0;
    wrap_top    = 5'd31;
    {jmp_pin, pins_in_base, pins_out_base, pins_set_base} = '0;
    pins_out_count = 6'd8;
    pins_set_count = 3'd1;
    {auto_push, auto_pull} = 2'b00;
    {isr_threshold, osr_threshold} = '0;
    {in_shift_dir, out_shift_dir} = 2'b11;
    tx_fifo.delete();
    rx_expected.delete();
    for (i = 0; i < 32; i++) prog[i] = encode(OP_JMP, COND_ALWAYS, 5'(i)); // Halt in place
  endtask

  task automatic begin_test(input string name);
    next_cycle();
    test_name = name;
    reset = 1'b1;
    en    = 1'b0;
    load_defaults();
  endtask

  task automatic release_reset();
    repeat (10) next_cycle();
    reset = 1'b0;
    next_cycle();
    en = 1'b1; // Enable one cycle after reset
  endtask

  task automatic wait_rx_words(input int n, input int max_cycles);
    int cycles;
    cycles = 0;
    while (rx_fifo.size() < n && cycles < max_cycles) begin
      next_cycle();
      cycles++;
    end
    if (rx_fifo.size() < n) begin
      other_errors++;
      $display("%s: timed out with %0d of %0d RX words", test_name, rx_fifo.size(), n);
    end
  endtask

  task automatic wait_pc(input pc_t target, input int max_cycles);
    int cycles;
    cycles = 0;
    while (pc != target && cycles < max_cycles) begin
      next_cycle();
      cycles++;
    end
    if (pc != target) begin
      other_errors++;
      $display("%s: program did not reach address %0d", test_name, target);
    end
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual == expected) else begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic run_byte_path(input string name, input logic od, input logic idir,
                               input int nwords, input logic random_mode);
    word_t w;
    int i;
    begin_test(name);
    out_shift_dir = od;
    in_shift_dir  = idir;
    auto_push     = 1'b1;
    wrap_top      = 5'd8;
    prog[0] = encode(OP_PUSH_PULL, 3'b101, 5'd0); // PULL block
    for (i = 0; i < 4; i++) begin
      prog[1 + 2 * i] = encode(OP_OUT, DST_X, 5'd8);
      prog[2 + 2 * i] = encode(OP_IN, SRC_X, 5'd8);
    end
    for (i = 0; i <= nwords; i++) begin
      w = $random(seed);
      tx_fifo.push_back(w);
      if (i < nwords) rx_expected.push_back(expected_rx_word(w, od, idir));
    end // Last word only flushes the previous one
    random_flags = random_mode;
    release_reset();
    wait_rx_words(nwords, nwords * WORD_CYCLES);
    repeat (20) next_cycle();
  endtask

  task automatic run_loop(input int n);
    begin_test($sformatf("loop_%0d", n));
    pins_set_base = 5'd7;
    prog[0] = encode(OP_SET, DST_X, 5'(n));
    prog[1] = encode(OP_SET, DST_PINS, 5'd1);
    prog[2] = encode(OP_SET, DST_PINS, 5'd0);
    prog[3] = encode(OP_JMP, COND_X_DEC, 5'd1);
    release_reset();
    wait_pc(5'd4, LOOP_CYCLES);
    repeat (2) next_cycle();
    check_value(test_name, 32'(n + 1), 32'(edge_count));
  endtask

  task automatic run_wait_pin();
    word_t pins;
    begin_test("wait_pin");
    pins_in_base = 5'd5;
    pins = $random(seed);
    pins[8] = 1'b0; // Waited pin is base + 3
    input_pins = pins;
    prog[0] = encode(OP_WAIT, 3'b101, 5'd3);
    prog[1] = encode(OP_IN, SRC_PINS, 5'd0);
    prog[2] = encode(OP_PUSH_PULL, 3'b001, 5'd0);
    release_reset();
    repeat (30) next_cycle();
    assert (stalled) else begin
      other_errors++;
      $display("%s: WAIT did not stall while the pin was low", test_name);
    end
    pins[8] = 1'b1;
    rx_expected.push_back(rotate_right(pins, 5));
    input_pins = pins;
    wait_rx_words(1, WAIT_CYCLES);
  endtask

  task automatic run_pin_out(input string name, input logic [4:0] v, input logic [4:0] k,
                             input pin_idx_t base);
    word_t expected;
    word_t expected_dirs;
    begin_test(name);
    hold_empty     = 1'b1;
    pins_set_base  = 5'd20;
    pins_set_count = 3'd5;
    pins_out_base  = base;
    pins_out_count = {1'b0, k};
    prog[0] = encode(OP_SET, DST_PINS, 5'd31);
    prog[1] = encode(OP_SET, DST_X, v);
    prog[2] = encode(OP_PUSH_PULL, 3'b100, 5'd0); // PULL noblock loads X into the OSR
    prog[3] = encode(OP_OUT, DST_PINS, k);
    prog[4] = encode(OP_SET, DST_PINDIRS, v); // Directions from the set base
    release_reset();
    wait_pc(5'd5, PIN_CYCLES);
    next_cycle();
    expected = expected_pins(expected_pins('0, 32'd31, 20, 5), {27'd0, v}, base, k);
    expected_dirs = expected_pins('0, {27'd0, v}, 20, 5);
    check_value(name, expected, output_pins);
    check_value($sformatf("%s_dirs", name), expected_dirs, pin_directions);
  endtask

  initial begin
    seed  = 32'h0942_83ea;
    reset = 1'b1;
    en    = 1'b0;
    load_defaults();
    run_byte_path("byte_path", 1'b0, 1'b1, BYTE_WORDS, 1'b0);
    run_byte_path("back_pressure", 1'b1, 1'b0, RANDOM_WORDS, 1'b1);
    run_loop(0);
    run_loop(3);
    run_loop(11);
    run_wait_pin();
    run_pin_out("pin_out_mid", 5'b10110, 5'd4, 5'd18);
    run_pin_out("pin_out_wrap", 5'b01101, 5'd5, 5'd30);
    $display("Errors: %0d wrong values, %0d other failures",
             value_errors + rx_mismatches, other_errors + fifo_faults);
    if (value_errors + rx_mismatches + other_errors + fifo_faults == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/pio_pkg.sv
design/pio_shift_if.sv
design/pio_shift_in.sv
design/pio_shift_out.sv
design/pio_exec.sv
design/pio_machine.sv
testbench/pio_machine_sva.sv
testbench/tb_pio_machine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PIO core testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module tb_pio_machine \
  -o tb_pio_machine \
  && ./obj_dir/tb_pio_machine > sim.log 2>&1 \
  || echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
  && echo "Run passed" \
  || { echo "Run failed, see sim.log"; exit 1; }
